//--- hdl/axi_mem_pkg.sv
/* Shared AXI widths, channel structs and state enums. The data bus is fixed at 32 bits.
   WRAP and reserved burst codes exist only so that they can be flagged. */
package axi_mem_pkg;

    localparam int ID_W       = 4;
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int BYTE_OFS_W = 2;     // log2 of STRB_W

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,    // not served
        BURST_RSVD  = 2'b11
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // ----------------------------------------------------------
    // channel payloads
    // ----------------------------------------------------------
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;    // beats minus one
        logic [2:0]        size;   // log2 bytes per beat
        burst_e            burst;
    } axi_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } b_rsp_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
        logic              last;
    } r_beat_t;

    // rides alongside each RAM read
    typedef struct packed {
        logic [ID_W-1:0] id;
        logic            last;
    } rd_tag_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_ISSUE
    } rd_state_e;

endpackage

//--- hdl/mem_array.sv
/* Byte-enabled word RAM with one write and one registered read port.
   A read of a word written on the same edge returns the old data. */
`timescale 1ns/10ps

module mem_array #(
    parameter  int MEM_BYTES = 1024,
    localparam int WORDS     = MEM_BYTES / axi_mem_pkg::STRB_W,
    localparam int WORD_AW   = $clog2(WORDS)
) (
    input  logic                            CLK,
    input  logic [axi_mem_pkg::STRB_W-1:0]  wen,
    input  logic [WORD_AW-1:0]              waddr,
    input  logic [axi_mem_pkg::DATA_W-1:0]  wdata,
    input  logic                            ren,
    input  logic [WORD_AW-1:0]              raddr,
    output logic [axi_mem_pkg::DATA_W-1:0]  rdata
);

    logic [axi_mem_pkg::DATA_W-1:0] mem [WORDS];

    // per-byte lanes
    always_ff @(posedge CLK) begin
        for (int i = 0; i < axi_mem_pkg::STRB_W; i++) begin
            if (wen[i]) begin
                mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // holds the last word read until the next ren
    always_ff @(posedge CLK) begin
        if (ren) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- hdl/burst_addr_gen.sv
/* Byte address of the current beat within a burst. INCR steps are aligned to the
   transfer size and wrap at MEM_BYTES, and any other burst type holds the address. */
`timescale 1ns/10ps

module burst_addr_gen #(
    parameter  int MEM_BYTES = 1024,
    localparam int AW        = $clog2(MEM_BYTES)
) (
    input  logic                  CLK,
    input  logic                  axi_aresetn,
    input  logic                  load,
    input  logic                  step,
    input  axi_mem_pkg::axi_req_t req,
    output logic [AW-1:0]         addr
);

    logic [2:0]          size_q;
    axi_mem_pkg::burst_e burst_q;
    logic [AW-1:0]       bytes;     // bytes per beat

    assign bytes = AW'(1) << size_q;

    always_ff @(posedge CLK or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            addr    <= '0;
            size_q  <= '0;
            burst_q <= axi_mem_pkg::BURST_FIXED;
        end else if (load) begin
            addr    <= req.addr[AW-1:0];    // modulo memory size
            size_q  <= req.size;
            burst_q <= req.burst;
        end else if (step && (burst_q == axi_mem_pkg::BURST_INCR)) begin
            // align down first so an unaligned start lands on the next boundary
            addr <= (addr & ~(bytes - AW'(1))) + bytes;
        end
    end

endmodule

//--- hdl/read_out_buf.sv
/* Two-entry R-channel buffer behind the RAM read port. The issuer must hold off
   while can_issue is low, since occupancy plus the read in flight may not exceed two. */
`timescale 1ns/10ps

module read_out_buf (
    input  logic                            CLK,
    input  logic                            axi_aresetn,
    input  logic                            ren,
    input  axi_mem_pkg::rd_tag_t            tag,
    input  logic [axi_mem_pkg::DATA_W-1:0]  rdata,
    output logic                            can_issue,
    output axi_mem_pkg::r_beat_t            r,
    output logic                            r_valid,
    input  logic                            r_ready
);

    axi_mem_pkg::r_beat_t fifo [2];
    axi_mem_pkg::rd_tag_t tag_q;      // tag of the read in flight
    logic                 pend_q;     // rdata arrives this cycle
    logic                 wr_ptr;
    logic                 rd_ptr;
    logic [1:0]           count;
    logic                 push;
    logic                 pop;

    assign push      = pend_q;
    assign pop       = r_valid && r_ready;
    assign r_valid   = (count != 2'd0);
    assign r         = fifo[rd_ptr];
    assign can_issue = ({1'b0, count} + {2'b00, pend_q}) < 3'd2;

    // ----------------------------------------------------------
    // pointers and occupancy
    // ----------------------------------------------------------
    always_ff @(posedge CLK or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            pend_q <= 1'b0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= '0;
        end else begin
            pend_q <= ren;
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge CLK) begin
        if (ren) begin
            tag_q <= tag;
        end
        if (push) begin
            fifo[wr_ptr] <= '{id: tag_q.id, data: rdata,
                              resp: axi_mem_pkg::RESP_OKAY, last: tag_q.last};
        end
    end

    // stalled head must not move
    a_r_stable: assert property (@(posedge CLK) disable iff (!axi_aresetn)
        r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

//--- hdl/axi_mem_ctrl.sv
/* Write and read channel machines. A missing WLAST on the final beat gives SLVERR,
   and ar_ready returns once the last read of a burst has been issued. */
`timescale 1ns/10ps

module axi_mem_ctrl #(
    parameter  int MEM_BYTES = 1024,
    localparam int AW        = $clog2(MEM_BYTES)
) (
    input  logic                            CLK,
    input  logic                            axi_aresetn,
    input  axi_mem_pkg::axi_req_t           aw,
    input  logic                            aw_valid,
    output logic                            aw_ready,
    input  axi_mem_pkg::w_beat_t            w,
    input  logic                            w_valid,
    output logic                            w_ready,
    output axi_mem_pkg::b_rsp_t             b,
    output logic                            b_valid,
    input  logic                            b_ready,
    input  axi_mem_pkg::axi_req_t           ar,
    input  logic                            ar_valid,
    output logic                            ar_ready,
    output logic                            wr_load,
    output logic                            wr_step,
    output logic                            rd_load,
    output logic                            rd_step,
    output axi_mem_pkg::axi_req_t           wr_req,
    output axi_mem_pkg::axi_req_t           rd_req,
    input  logic [AW-1:0]                   wr_addr,
    input  logic [AW-1:0]                   rd_addr,
    output logic [axi_mem_pkg::STRB_W-1:0]  mem_wen,
    output logic [AW-1:0]                   mem_waddr,
    output logic [axi_mem_pkg::DATA_W-1:0]  mem_wdata,
    output logic                            mem_ren,
    output logic [AW-1:0]                   mem_raddr,
    output axi_mem_pkg::rd_tag_t            rd_tag,
    input  logic                            can_issue
);

    axi_mem_pkg::wr_state_e         wr_state;
    axi_mem_pkg::rd_state_e         rd_state;
    logic                           aw_hs;
    logic                           w_hs;
    logic                           ar_hs;
    logic [7:0]                     wr_len;
    logic [7:0]                     wr_cnt;    // beats accepted so far
    logic [7:0]                     rd_len;
    logic [7:0]                     rd_cnt;    // reads issued so far
    logic [axi_mem_pkg::ID_W-1:0]   rd_id;

    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid && w_ready;
    assign ar_hs = ar_valid && ar_ready;

    // generators load straight from the address channel
    assign wr_load = aw_hs;
    assign wr_req  = aw;
    assign wr_step = w_hs;
    assign rd_load = ar_hs;
    assign rd_req  = ar;

    // ----------------------------------------------------------
    // write channel
    // ----------------------------------------------------------
    always_ff @(posedge CLK or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            wr_state <= axi_mem_pkg::WR_IDLE;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            b        <= '0;
            wr_len   <= '0;
            wr_cnt   <= '0;
            mem_wen  <= '0;
        end else begin
            mem_wen <= '0;
            case (wr_state)
                axi_mem_pkg::WR_IDLE: begin
                    if (aw_hs) begin
                        aw_ready <= 1'b0;
                        w_ready  <= 1'b1;
                        b.id     <= aw.id;
                        wr_len   <= aw.len;
                        wr_cnt   <= '0;
                        wr_state <= axi_mem_pkg::WR_DATA;
                    end else begin
                        aw_ready <= 1'b1;
                    end
                end
                axi_mem_pkg::WR_DATA: begin
                    if (w_hs) begin
                        mem_wen <= w.strb;    // RAM write lands next edge
                        wr_cnt  <= wr_cnt + 8'd1;
                        // count decides the end, WLAST only grades it
                        if (wr_cnt == wr_len) begin
                            w_ready  <= 1'b0;
                            b.resp   <= w.last ? axi_mem_pkg::RESP_OKAY
                                               : axi_mem_pkg::RESP_SLVERR;
                            wr_state <= axi_mem_pkg::WR_RESP;
                        end
                    end
                end
                axi_mem_pkg::WR_RESP: begin
                    if (!b_valid) begin
                        b_valid <= 1'b1;    // final beat reaches the RAM on this edge
                    end else if (b_ready) begin
                        b_valid  <= 1'b0;
                        aw_ready <= 1'b1;
                        wr_state <= axi_mem_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= axi_mem_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (w_hs) begin
            mem_waddr <= wr_addr;
            mem_wdata <= w.data;
        end
    end

    // ----------------------------------------------------------
    // read channel
    // ----------------------------------------------------------
    assign mem_ren   = (rd_state == axi_mem_pkg::RD_ISSUE) && can_issue;
    assign mem_raddr = rd_addr;
    assign rd_step   = mem_ren;
    assign rd_tag    = '{id: rd_id, last: (rd_cnt == rd_len)};

    always_ff @(posedge CLK or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            rd_state <= axi_mem_pkg::RD_IDLE;
            ar_ready <= 1'b0;
            rd_id    <= '0;
            rd_len   <= '0;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                axi_mem_pkg::RD_IDLE: begin
                    if (ar_hs) begin
                        ar_ready <= 1'b0;
                        rd_id    <= ar.id;
                        rd_len   <= ar.len;
                        rd_cnt   <= '0;
                        rd_state <= axi_mem_pkg::RD_ISSUE;
                    end else begin
                        ar_ready <= 1'b1;
                    end
                end
                axi_mem_pkg::RD_ISSUE: begin
                    if (mem_ren) begin
                        rd_cnt <= rd_cnt + 8'd1;
                        // buffer keeps order, so the next AR may start early
                        if (rd_cnt == rd_len) begin
                            rd_state <= axi_mem_pkg::RD_IDLE;
                        end
                    end
                end
                default: rd_state <= axi_mem_pkg::RD_IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    a_aw_req: assert property (@(posedge CLK) disable iff (!axi_aresetn)
        aw_hs |-> (aw.burst inside {axi_mem_pkg::BURST_FIXED, axi_mem_pkg::BURST_INCR})
                  && (aw.size <= 3'(axi_mem_pkg::BYTE_OFS_W)));

    a_ar_req: assert property (@(posedge CLK) disable iff (!axi_aresetn)
        ar_hs |-> (ar.burst inside {axi_mem_pkg::BURST_FIXED, axi_mem_pkg::BURST_INCR})
                  && (ar.size <= 3'(axi_mem_pkg::BYTE_OFS_W)));

    // a raised write response holds until the master takes it
    a_b_hold: assert property (@(posedge CLK) disable iff (!axi_aresetn)
        b_valid && !b_ready |=> b_valid && $stable(b));

endmodule

//--- hdl/axi_mem_top.sv
/* AXI4 memory slave with FIXED and INCR bursts of up to 256 beats.
   MEM_BYTES must be a power of two, and addresses wrap modulo MEM_BYTES. */
`timescale 1ns/10ps

module axi_mem_top #(
    parameter  int MEM_BYTES = 1024,
    localparam int AW        = $clog2(MEM_BYTES)
) (
    input  logic                  CLK,
    input  logic                  axi_aresetn,
    input  axi_mem_pkg::axi_req_t aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_mem_pkg::w_beat_t  w,
    input  logic                  w_valid,
    output logic                  w_ready,
    output axi_mem_pkg::b_rsp_t   b,
    output logic                  b_valid,
    input  logic                  b_ready,
    input  axi_mem_pkg::axi_req_t ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output axi_mem_pkg::r_beat_t  r,
    output logic                  r_valid,
    input  logic                  r_ready
);

    logic                               wr_load;
    logic                               wr_step;
    logic                               rd_load;
    logic                               rd_step;
    axi_mem_pkg::axi_req_t              wr_req;
    axi_mem_pkg::axi_req_t              rd_req;
    logic [AW-1:0]                      wr_addr;
    logic [AW-1:0]                      rd_addr;
    logic [axi_mem_pkg::STRB_W-1:0]     mem_wen;
    logic [AW-1:0]                      mem_waddr;    // byte address
    logic [axi_mem_pkg::DATA_W-1:0]     mem_wdata;
    logic                               mem_ren;
    logic [AW-1:0]                      mem_raddr;    // byte address
    logic [axi_mem_pkg::DATA_W-1:0]     mem_rdata;
    axi_mem_pkg::rd_tag_t               rd_tag;
    logic                               can_issue;

    axi_mem_ctrl #(.MEM_BYTES(MEM_BYTES)) i_ctrl (
        .CLK         (CLK),
        .axi_aresetn (axi_aresetn),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .b           (b),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .ar          (ar),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .wr_load     (wr_load),
        .wr_step     (wr_step),
        .rd_load     (rd_load),
        .rd_step     (rd_step),
        .wr_req      (wr_req),
        .rd_req      (rd_req),
        .wr_addr     (wr_addr),
        .rd_addr     (rd_addr),
        .mem_wen     (mem_wen),
        .mem_waddr   (mem_waddr),
        .mem_wdata   (mem_wdata),
        .mem_ren     (mem_ren),
        .mem_raddr   (mem_raddr),
        .rd_tag      (rd_tag),
        .can_issue   (can_issue)
    );

    burst_addr_gen #(.MEM_BYTES(MEM_BYTES)) i_wr_addr (
        .CLK         (CLK),
        .axi_aresetn (axi_aresetn),
        .load        (wr_load),
        .step        (wr_step),
        .req         (wr_req),
        .addr        (wr_addr)
    );

    burst_addr_gen #(.MEM_BYTES(MEM_BYTES)) i_rd_addr (
        .CLK         (CLK),
        .axi_aresetn (axi_aresetn),
        .load        (rd_load),
        .step        (rd_step),
        .req         (rd_req),
        .addr        (rd_addr)
    );

    // word index drops the byte offset
    mem_array #(.MEM_BYTES(MEM_BYTES)) i_mem (
        .CLK   (CLK),
        .wen   (mem_wen),
        .waddr (mem_waddr[AW-1:axi_mem_pkg::BYTE_OFS_W]),
        .wdata (mem_wdata),
        .ren   (mem_ren),
        .raddr (mem_raddr[AW-1:axi_mem_pkg::BYTE_OFS_W]),
        .rdata (mem_rdata)
    );

    read_out_buf i_rbuf (
        .CLK         (CLK),
        .axi_aresetn (axi_aresetn),
        .ren         (mem_ren),
        .tag         (rd_tag),
        .rdata       (mem_rdata),
        .can_issue   (can_issue),
        .r           (r),
        .r_valid     (r_valid),
        .r_ready     (r_ready)
    );

endmodule

//--- sim/axi_mem_checker.sv
/* Scoreboard for the AXI4 memory slave. It sees only the DUT ports and assumes
   one write burst at a time and no write while a read burst is outstanding. */
`timescale 1ns/10ps

module axi_mem_checker #(
    parameter int MEM_BYTES = 1024
) (
    input  logic                  CLK,
    input  logic                  axi_aresetn,
    input  axi_mem_pkg::axi_req_t aw,
    input  logic                  aw_valid,
    input  logic                  aw_ready,
    input  axi_mem_pkg::w_beat_t  w,
    input  logic                  w_valid,
    input  logic                  w_ready,
    input  axi_mem_pkg::b_rsp_t   b,
    input  logic                  b_valid,
    input  logic                  b_ready,
    input  axi_mem_pkg::axi_req_t ar,
    input  logic                  ar_valid,
    input  logic                  ar_ready,
    input  axi_mem_pkg::r_beat_t  r,
    input  logic                  r_valid,
    input  logic                  r_ready,
    input  logic [127:0]          test_name,
    input  logic                  test_done,
    output int                    errors
);

    logic [7:0]            model [MEM_BYTES];    // byte image of the RAM
    axi_mem_pkg::b_rsp_t   b_exp [$];
    axi_mem_pkg::r_beat_t  r_exp [$];
    axi_mem_pkg::axi_req_t wr_req;
    axi_mem_pkg::b_rsp_t   b_want;
    axi_mem_pkg::r_beat_t  r_want;
    axi_mem_pkg::r_beat_t  r_held;     // payload seen during a stall
    int                    wr_addr;
    int                    wr_cnt;
    int                    err_count = 0;
    int                    test_errs = 0;
    logic                  stalled   = 1'b0;
    string                 tname;

    assign errors = err_count;

    // FIXED holds, INCR aligns down and steps by the beat size
    function automatic int next_addr(input int a, input axi_mem_pkg::axi_req_t req);
        int nb;
        nb = 1 << req.size;
        if (req.burst != axi_mem_pkg::BURST_INCR) begin
            return a;
        end
        return ((a & ~(nb - 1)) + nb) % MEM_BYTES;
    endfunction

    function automatic logic [31:0] ref_word(input int a);
        int base;
        base = (a % MEM_BYTES) & ~3;
        return {model[base + 3], model[base + 2], model[base + 1], model[base]};
    endfunction

    task automatic count_error();
        err_count++;
        test_errs++;
    endtask

    task automatic write_model(input axi_mem_pkg::w_beat_t beat);
        int base;
        base = wr_addr & ~3;
        for (int i = 0; i < 4; i++) begin
            if (beat.strb[i]) begin
                model[base + i] = beat.data[8*i +: 8];
            end
        end
        if (wr_cnt == int'(wr_req.len)) begin    // count ends the burst, not WLAST
            b_want.id   = wr_req.id;
            b_want.resp = beat.last ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
            b_exp.push_back(b_want);
        end
        wr_cnt++;
        wr_addr = next_addr(wr_addr, wr_req);
    endtask

    task automatic expect_read(input axi_mem_pkg::axi_req_t req);
        int a;
        axi_mem_pkg::r_beat_t beat;
        a = req.addr % MEM_BYTES;
        for (int i = 0; i <= int'(req.len); i++) begin
            beat.id   = req.id;
            beat.data = ref_word(a);
            beat.resp = axi_mem_pkg::RESP_OKAY;
            beat.last = (i == int'(req.len));
            r_exp.push_back(beat);
            a = next_addr(a, req);
        end
    endtask

    // ----------------------------------------------------------
    // sampled on the rising edge, before the DUT updates
    // ----------------------------------------------------------
    always @(posedge CLK) begin
        tname = string'(test_name);
        if (axi_aresetn) begin
            if (aw_valid && aw_ready) begin
                wr_req  = aw;
                wr_addr = aw.addr % MEM_BYTES;
                wr_cnt  = 0;
            end
            if (w_valid && w_ready) begin
                write_model(w);
            end
            if (b_valid && b_ready) begin
                if (b_exp.size() == 0) begin
                    $display("test %0s: B response arrived with no write outstanding", tname);
                    count_error();
                end else begin
                    b_want = b_exp.pop_front();
                    if (b !== b_want) begin
                        $display("Fail %0s: B expected %h actual %h", tname, b_want, b);
                        count_error();
                    end
                end
            end
            if (ar_valid && ar_ready) begin
                expect_read(ar);
            end
            if (stalled && (!r_valid || r !== r_held)) begin
                $display("Fail %0s: stalled R expected %h actual %h", tname, r_held, r);
                count_error();
            end
            if (r_valid && r_ready) begin
                if (r_exp.size() == 0) begin
                    $display("test %0s: R beat arrived with no read outstanding", tname);
                    count_error();
                end else begin
                    r_want = r_exp.pop_front();
                    if (r !== r_want) begin
                        $display("Fail %0s: R expected %h actual %h", tname, r_want, r);
                        count_error();
                    end
                end
            end
            stalled = r_valid && !r_ready;
            r_held  = r;
            if (test_done) begin
                if (b_exp.size() != 0 || r_exp.size() != 0 || b_valid || r_valid) begin
                    $display("test %0s: responses were lost or are still pending", tname);
                    count_error();
                end
                if (test_errs == 0) begin
                    $display("test %0s: ok", tname);
                end else begin
                    $display("test %0s: %0d errors", tname, test_errs);
                end
                test_errs = 0;
            end
        end
    end

endmodule

//--- sim/tb_axi_mem.sv
/* Testbench for the AXI4 memory slave. Inputs change on the falling edge and
   every wait gives up after TIMEOUT cycles. */
`timescale 1ns/10ps

module tb_axi_mem;

    localparam int MEM_BYTES = 1024;
    localparam int TIMEOUT   = 200;

    logic                  CLK;
    logic                  axi_aresetn;
    axi_mem_pkg::axi_req_t aw;
    logic                  aw_valid;
    logic                  aw_ready;
    axi_mem_pkg::w_beat_t  w;
    logic                  w_valid;
    logic                  w_ready;
    axi_mem_pkg::b_rsp_t   b;
    logic                  b_valid;
    logic                  b_ready;
    axi_mem_pkg::axi_req_t ar;
    logic                  ar_valid;
    logic                  ar_ready;
    axi_mem_pkg::r_beat_t  r;
    logic                  r_valid;
    logic                  r_ready;
    logic [127:0]          test_name;
    logic                  test_done;
    int                    errors;
    int                    tests;

    initial begin
        CLK = 1'b0;
        forever begin
            #4 CLK = ~CLK;    // 8 ns period
        end
    end

    axi_mem_top #(.MEM_BYTES(MEM_BYTES)) i_dut (.*);

    axi_mem_checker #(.MEM_BYTES(MEM_BYTES)) i_chk (.*);

    task automatic timed_out(input string what);
        $display("timeout: %0s did not happen in test %0s", what, string'(test_name));
        $display("tests: %0d, errors: %0d", tests, errors + 1);
        $display("Done: errors found");
        $finish;
    endtask

    // byte lanes a beat of this size may use at address a
    function automatic logic [3:0] lane_mask(input int a, input int size);
        int nb;
        nb = 1 << size;
        return 4'(((1 << nb) - 1) << (a & (4 - nb)));
    endfunction

    task automatic finish_test();
        test_done = 1'b1;
        @(negedge CLK);
        test_done = 1'b0;
        tests++;
    endtask

    // ----------------------------------------------------------
    // strb_sel of zero picks random strobes
    // ----------------------------------------------------------
    task automatic write_burst(input logic [3:0] id, input int addr, input int len,
                               input int size, input axi_mem_pkg::burst_e burst,
                               input logic [3:0] strb_sel, input bit drop_last);
        int a;
        int n;
        int i;
        aw       = '{id: id, addr: 32'(addr), len: 8'(len), size: 3'(size), burst: burst};
        aw_valid = 1'b1;
        n = 0;
        while (!aw_ready && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (n >= TIMEOUT) timed_out("AW handshake");
        @(negedge CLK);
        aw_valid = 1'b0;
        a = addr % MEM_BYTES;
        for (i = 0; i <= len; i++) begin
            w.data  = $urandom();
            w.strb  = ((strb_sel != 4'd0) ? strb_sel : 4'($urandom())) & lane_mask(a, size);
            w.last  = (i == len) && !drop_last;
            w_valid = 1'b1;
            n = 0;
            while (!w_ready && n < TIMEOUT) begin
                @(negedge CLK);
                n++;
            end
            if (n >= TIMEOUT) timed_out("W handshake");
            @(negedge CLK);
            if (burst == axi_mem_pkg::BURST_INCR) begin
                a = ((a & ~((1 << size) - 1)) + (1 << size)) % MEM_BYTES;
            end
        end
        w_valid = 1'b0;
        n = 0;
        while (!b_valid && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (n >= TIMEOUT) timed_out("B response");
        @(negedge CLK);    // b_ready stays high
    endtask

    task automatic read_burst(input logic [3:0] id, input int addr, input int len,
                              input int size, input axi_mem_pkg::burst_e burst,
                              input bit stall);
        int n;
        int got;
        ar       = '{id: id, addr: 32'(addr), len: 8'(len), size: 3'(size), burst: burst};
        ar_valid = 1'b1;
        n = 0;
        while (!ar_ready && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (n >= TIMEOUT) timed_out("AR handshake");
        @(negedge CLK);
        ar_valid = 1'b0;
        got = 0;
        n = 0;
        while (got <= len && n < TIMEOUT) begin
            r_ready = stall ? 1'($urandom() % 2) : 1'b1;
            if (r_valid && r_ready) begin
                got++;
                n = 0;
            end
            @(negedge CLK);
            n++;
        end
        r_ready = 1'b0;
        if (got <= len) timed_out("R beat");
    endtask

    initial begin
        int n;
        void'($urandom(44));
        axi_aresetn = 1'b0;
        aw          = '0;
        aw_valid    = 1'b0;
        w           = '0;
        w_valid     = 1'b0;
        b_ready     = 1'b1;
        ar          = '0;
        ar_valid    = 1'b0;
        r_ready     = 1'b0;
        test_done   = 1'b0;
        tests       = 0;
        test_name   = 128'("reset");
        repeat (3) @(negedge CLK);
        axi_aresetn = 1'b1;
        n = 0;
        while (!(aw_ready && ar_ready) && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (n >= TIMEOUT) timed_out("aw_ready and ar_ready after reset");
        finish_test();

        test_name = 128'("fill");    // whole RAM, so every byte is known
        write_burst(4'd1, 'h000, 255, 2, axi_mem_pkg::BURST_INCR, 4'hF, 1'b0);
        finish_test();

        test_name = 128'("single_rw");
        write_burst(4'd3, 'h040, 0, 2, axi_mem_pkg::BURST_INCR, 4'b0101, 1'b0);
        read_burst(4'd3, 'h040, 0, 2, axi_mem_pkg::BURST_INCR, 1'b0);
        finish_test();

        test_name = 128'("incr_burst");
        write_burst(4'd5, 'h100, 7, 2, axi_mem_pkg::BURST_INCR, 4'h0, 1'b0);
        write_burst(4'd6, 'h121, 5, 0, axi_mem_pkg::BURST_INCR, 4'h0, 1'b0);
        read_burst(4'd5, 'h100, 9, 2, axi_mem_pkg::BURST_INCR, 1'b0);
        finish_test();

        test_name = 128'("fixed_burst");
        write_burst(4'd7, 'h200, 3, 2, axi_mem_pkg::BURST_FIXED, 4'h0, 1'b0);
        read_burst(4'd7, 'h200, 2, 2, axi_mem_pkg::BURST_FIXED, 1'b0);
        finish_test();

        test_name = 128'("backpressure");
        read_burst(4'd2, 'h080, 15, 2, axi_mem_pkg::BURST_INCR, 1'b1);
        finish_test();

        test_name = 128'("missing_wlast");
        write_burst(4'd9, 'h300, 3, 2, axi_mem_pkg::BURST_INCR, 4'h0, 1'b1);
        read_burst(4'd9, 'h300, 3, 2, axi_mem_pkg::BURST_INCR, 1'b0);
        finish_test();

        $display("tests: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- axi_mem_top.f
hdl/axi_mem_pkg.sv
hdl/mem_array.sv
hdl/burst_addr_gen.sv
hdl/read_out_buf.sv
hdl/axi_mem_ctrl.sv
hdl/axi_mem_top.sv
sim/axi_mem_checker.sv
sim/tb_axi_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the AXI memory testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_axi_mem \
    -f axi_mem_top.f -o sim_axi_mem > build.log 2>&1 \
    && { ./obj_dir/sim_axi_mem > sim.log 2>&1 || true; } \
    && grep -qx "Done: no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
